/* logic/istream_pkg.sv */
// ----------------------------------------
// instruction stream buffer shared types
// constants for set, window and way sizes
// packed structs for blocks, window, ways
// and the dequeue pop command
// ----------------------------------------

package istream_pkg;

    // ----------------------------------------
    // sizes

    // 2-byte chunks in one fetch block
    localparam int CHUNKS_PER_SET = 8;

    // two head sets seen side by side
    localparam int WINDOW_CHUNKS = 2 * CHUNKS_PER_SET;
    localparam int WINDOW_IDX_W = $clog2(WINDOW_CHUNKS);

    // instructions issued per cycle
    localparam int NUM_WAYS = 4;

    // ----------------------------------------
    // types

    typedef logic [15:0] chunk_t;

    // one incoming fetch block, after_pc28 is PC[31:4] of the next block
    typedef struct packed {
        chunk_t [CHUNKS_PER_SET-1:0] chunks;
        logic [CHUNKS_PER_SET-1:0]   valid_mask;
        logic [27:0]                 after_pc28;
    } fetch_block_t;

    // head set in the low half, following set in the high half
    typedef struct packed {
        chunk_t [WINDOW_CHUNKS-1:0] chunks;
        logic [WINDOW_CHUNKS-1:0]   valid;
        logic [WINDOW_CHUNKS-1:0]   uncompressed;
        logic [WINDOW_CHUNKS-1:0]   marker;
        logic [27:0]                head_pc28;
        logic [27:0]                next_pc28;
    } window_t;

    // one issued instruction
    typedef struct packed {
        logic        valid;
        logic        uncompressed;
        chunk_t      lower;
        chunk_t      upper;
        logic [31:0] pc;
    } deq_way_t;

    // consumed chunks and how many head sets retire
    typedef struct packed {
        logic [WINDOW_CHUNKS-1:0] ack;
        logic                     pop_one;
        logic                     pop_two;
    } pop_t;

endpackage

/* logic/set_store.sv */
// ----------------------------------------
// circular set storage for fetch blocks
// enqueue and head pointers with wrap bit
// remaining-valid mask per set, head PC
// full, pop and restart handling
// ----------------------------------------

module set_store
    import istream_pkg::*;
#(
    parameter int          NUM_SETS = 8,
    parameter logic [31:0] INIT_PC  = 32'h8000_0000
) (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           enq_valid,
    input  fetch_block_t                   enq_block,
    output logic                           stall_enq,
    input  logic                           restart,
    input  logic [31:0]                    restart_pc,
    input  pop_t                           pop,
    output fetch_block_t [1:0]             head_blocks,
    output logic [1:0][CHUNKS_PER_SET-1:0] head_valid,
    output logic [27:0]                    head_pc28
);

    localparam int IDX_W = $clog2(NUM_SETS);

    typedef struct packed {
        logic             wrap;
        logic [IDX_W-1:0] idx;
    } set_ptr_t;

    fetch_block_t blocks [NUM_SETS];

    logic [NUM_SETS-1:0][CHUNKS_PER_SET-1:0] remain, next_remain;

    set_ptr_t enq_ptr;
    set_ptr_t head_ptr, next_head_ptr;
    set_ptr_t head1_ptr;

    logic [IDX_W:0] occupancy;
    logic           full;
    logic           present0;
    logic           present1;
    logic           enq_fire;
    logic [27:0]    next_head_pc28;

    // ----------------------------------------
    // pointer status

    assign head1_ptr = set_ptr_t'(head_ptr + 1'b1);
    assign occupancy = enq_ptr - head_ptr;

    // same slot, other lap
    assign full = (enq_ptr.idx == head_ptr.idx) & (enq_ptr.wrap != head_ptr.wrap);
    assign present0 = (occupancy != '0);
    assign present1 = (occupancy > 1);

    assign stall_enq = full;
    assign enq_fire = enq_valid & ~full;

    // ----------------------------------------
    // head sets out

    assign head_blocks[0] = blocks[head_ptr.idx];
    assign head_blocks[1] = blocks[head1_ptr.idx];

    // a set not yet enqueued shows no valid chunks
    assign head_valid[0] = present0 ? remain[head_ptr.idx] : '0;
    assign head_valid[1] = present1 ? remain[head1_ptr.idx] : '0;

    // block payload, written on enqueue only
    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            blocks[enq_ptr.idx] <= enq_block;
        end
    end

    always_comb begin
        next_remain = remain;
        next_head_ptr = head_ptr;
        next_head_pc28 = head_pc28;

        // drop chunks consumed this cycle
        next_remain[head_ptr.idx] = remain[head_ptr.idx] & ~pop.ack[CHUNKS_PER_SET-1:0];
        next_remain[head1_ptr.idx] =
            remain[head1_ptr.idx] & ~pop.ack[WINDOW_CHUNKS-1:CHUNKS_PER_SET];

        // new head PC comes from the last retired set
        if (pop.pop_two) begin
            next_head_ptr = set_ptr_t'(head_ptr + 2'd2);
            next_head_pc28 = head_blocks[1].after_pc28;
        end else if (pop.pop_one) begin
            next_head_ptr = head1_ptr;
            next_head_pc28 = head_blocks[0].after_pc28;
        end

        if (enq_fire) begin
            next_remain[enq_ptr.idx] = enq_block.valid_mask;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr <= '0;
            head_ptr <= '0;
            head_pc28 <= INIT_PC[31:4];
            remain <= '0;
        end else if (restart) begin
            // flush everything, resume at the new PC
            enq_ptr <= '0;
            head_ptr <= '0;
            head_pc28 <= restart_pc[31:4];
            remain <= '0;
        end else begin
            if (enq_fire) begin
                enq_ptr <= set_ptr_t'(enq_ptr + 1'b1);
            end
            head_ptr <= next_head_ptr;
            head_pc28 <= next_head_pc28;
            remain <= next_remain;
        end
    end

endmodule

/* logic/chunk_window.sv */
// ----------------------------------------
// two head sets as one 16-chunk window
// compressed decode and start markers
// ----------------------------------------

module chunk_window
    import istream_pkg::*;
(
    input  fetch_block_t [1:0]             head_blocks,
    input  logic [1:0][CHUNKS_PER_SET-1:0] head_valid,
    input  logic [27:0]                    head_pc28,
    output window_t                        window
);

    always_comb begin
        // head set low, following set high
        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
            window.chunks[i] = head_blocks[0].chunks[i];
            window.chunks[i + CHUNKS_PER_SET] = head_blocks[1].chunks[i];
        end
        window.valid = {head_valid[1], head_valid[0]};

        // low bits 11 means a 32-bit instruction
        for (int i = 0; i < WINDOW_CHUNKS; i++) begin
            window.uncompressed[i] = (window.chunks[i][1:0] == 2'b11);
        end
    end

    // ----------------------------------------
    // start markers

    // a chunk starts an instruction unless it is the upper half of the one before
    always_comb begin
        window.marker[0] = window.valid[0];
        for (int i = 1; i < WINDOW_CHUNKS; i++) begin
            window.marker[i] = window.valid[i]
                & ~(window.marker[i-1] & window.uncompressed[i-1]);
        end

        // no room left for an upper half
        if (window.uncompressed[WINDOW_CHUNKS-1]) begin
            window.marker[WINDOW_CHUNKS-1] = 1'b0;
        end
    end

    assign window.head_pc28 = head_pc28;
    assign window.next_pc28 = head_blocks[0].after_pc28;

endmodule

/* logic/way_extract.sv */
// ----------------------------------------
// one dequeue way
// picks lower and upper chunk, builds
// the instruction, its PC and its ack
// ----------------------------------------

module way_extract
    import istream_pkg::*;
(
    input  window_t                  window,
    input  logic [WINDOW_CHUNKS-1:0] consumed_in,
    output logic [WINDOW_CHUNKS-1:0] consumed_out,
    output deq_way_t                 way,
    output logic [WINDOW_CHUNKS-1:0] ack
);

    logic [WINDOW_CHUNKS-1:0] lower_req;
    logic [WINDOW_CHUNKS-1:0] upper_req;
    logic [WINDOW_CHUNKS-1:0] lower_thru;
    logic [WINDOW_IDX_W-1:0]  lower_idx;
    logic [WINDOW_IDX_W-1:0]  upper_idx;
    logic                     lower_found;
    logic                     upper_found;
    logic                     need_upper;
    logic                     way_ok;
    logic [27:0]              pc28;

    // lowest set bit, found flag on top
    function automatic logic [WINDOW_IDX_W:0] find_first(
        input logic [WINDOW_CHUNKS-1:0] req
    );
        logic [WINDOW_IDX_W:0] result;
        result = '0;
        for (int i = WINDOW_CHUNKS - 1; i >= 0; i--) begin
            if (req[i]) begin
                result = {1'b1, WINDOW_IDX_W'(i)};
            end
        end
        return result;
    endfunction

    // ----------------------------------------
    // chunk selection

    assign lower_req = window.marker & ~consumed_in;
    assign {lower_found, lower_idx} = find_first(lower_req);

    always_comb begin
        // no lower left means nothing for later ways either
        for (int i = 0; i < WINDOW_CHUNKS; i++) begin
            lower_thru[i] = ~lower_found | (i <= int'(lower_idx));
        end
    end

    // upper half is simply the next valid chunk
    assign upper_req = window.valid & ~lower_thru;
    assign {upper_found, upper_idx} = find_first(upper_req);

    assign need_upper = window.uncompressed[lower_idx];
    assign way_ok = lower_found & (~need_upper | upper_found);

    // PC set follows the lower chunk
    assign pc28 = lower_idx[WINDOW_IDX_W-1] ? window.next_pc28 : window.head_pc28;

    always_comb begin
        way = '0;
        ack = '0;
        if (way_ok) begin
            way.valid = 1'b1;
            way.uncompressed = need_upper;
            way.lower = window.chunks[lower_idx];
            way.upper = need_upper ? window.chunks[upper_idx] : '0;
            way.pc = {pc28, lower_idx[WINDOW_IDX_W-2:0], 1'b0};
            ack[lower_idx] = 1'b1;
            if (need_upper) begin
                ack[upper_idx] = 1'b1;
            end
        end
    end

    assign consumed_out = lower_thru;

endmodule

/* logic/deq_merge.sv */
// ----------------------------------------
// merges way acks into the pop command
// detects fully consumed head sets
// ----------------------------------------

module deq_merge
    import istream_pkg::*;
(
    input  logic [NUM_WAYS-1:0][WINDOW_CHUNKS-1:0] way_acks,
    input  window_t                                window,
    input  logic                                   stall_deq,
    output pop_t                                   pop
);

    logic [WINDOW_CHUNKS-1:0]         ack_all;
    logic [1:0][CHUNKS_PER_SET-1:0]   half_valid;
    logic [1:0][CHUNKS_PER_SET-1:0]   half_ack;
    logic [1:0]                       half_done;

    always_comb begin
        ack_all = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            ack_all = ack_all | way_acks[w];
        end

        // nothing is consumed while the consumer stalls
        if (stall_deq) begin
            ack_all = '0;
        end
    end

    // ----------------------------------------
    // head set retire check

    always_comb begin
        for (int h = 0; h < 2; h++) begin
            half_valid[h] = window.valid[h*CHUNKS_PER_SET +: CHUNKS_PER_SET];
            half_ack[h] = ack_all[h*CHUNKS_PER_SET +: CHUNKS_PER_SET];

            // done once every remaining valid chunk is taken now
            half_done[h] = (|half_valid[h])
                & ((half_valid[h] & ~half_ack[h]) == '0);
        end
    end

    assign pop.ack = ack_all;
    assign pop.pop_two = half_done[0] & half_done[1];
    assign pop.pop_one = half_done[0] & ~half_done[1];

endmodule

/* logic/istream.sv */
// ----------------------------------------
// instruction stream buffer top level
// set storage, window, four ways, merge
// ----------------------------------------

module istream
    import istream_pkg::*;
#(
    parameter int          NUM_SETS = 8,
    parameter logic [31:0] INIT_PC  = 32'h8000_0000
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     enq_valid,
    input  fetch_block_t             enq_block,
    output logic                     stall_enq,
    output logic                     deq_valid,
    output deq_way_t [NUM_WAYS-1:0]  deq_ways,
    input  logic                     stall_deq,
    input  logic                     restart,
    input  logic [31:0]              restart_pc
);

    fetch_block_t [1:0]                     head_blocks;
    logic [1:0][CHUNKS_PER_SET-1:0]         head_valid;
    logic [27:0]                            head_pc28;
    window_t                                window;
    logic [NUM_WAYS:0][WINDOW_CHUNKS-1:0]   consumed;
    logic [NUM_WAYS-1:0][WINDOW_CHUNKS-1:0] way_acks;
    pop_t                                   pop;

    set_store #(
        .NUM_SETS (NUM_SETS),
        .INIT_PC  (INIT_PC)
    ) i_set_store (
        .CLK         (CLK),
        .nRST        (nRST),
        .enq_valid   (enq_valid),
        .enq_block   (enq_block),
        .stall_enq   (stall_enq),
        .restart     (restart),
        .restart_pc  (restart_pc),
        .pop         (pop),
        .head_blocks (head_blocks),
        .head_valid  (head_valid),
        .head_pc28   (head_pc28)
    );

    chunk_window i_chunk_window (
        .head_blocks (head_blocks),
        .head_valid  (head_valid),
        .head_pc28   (head_pc28),
        .window      (window)
    );

    // ----------------------------------------
    // way chain, oldest instruction in way 0

    assign consumed[0] = '0;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        way_extract i_way_extract (
            .window       (window),
            .consumed_in  (consumed[w]),
            .consumed_out (consumed[w+1]),
            .way          (deq_ways[w]),
            .ack          (way_acks[w])
        );
    end

    deq_merge i_deq_merge (
        .way_acks  (way_acks),
        .window    (window),
        .stall_deq (stall_deq),
        .pop       (pop)
    );

    assign deq_valid = deq_ways[0].valid;

endmodule

/* bench/tb_istream.sv */
// ----------------------------------------
// testbench for the instruction stream buffer
// LCG stimulus, queue based reference model
// directed tests, random traffic, timeout
// ----------------------------------------

module tb_istream
    import istream_pkg::*;
();

    localparam int          NUM_SETS   = 8;
    localparam logic [31:0] INIT_PC    = 32'h0000_1000;
    localparam int          MAX_CYCLES = 2000;

    logic                    CLK;
    logic                    nRST;
    logic                    enq_valid;
    fetch_block_t            enq_block;
    logic                    stall_enq;
    logic                    deq_valid;
    deq_way_t [NUM_WAYS-1:0] deq_ways;
    logic                    stall_deq;
    logic                    restart;
    logic [31:0]             restart_pc;

    // reference model queue
    // valid_mask of each entry holds the chunks still pending
    fetch_block_t model_blocks[$];
    logic [27:0]  model_pc28;

    logic [31:0] lcg_state;
    logic [27:0] fetch_pc28;
    int          cycles = 0;
    int          checks = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          issued = 0;

    istream #(
        .NUM_SETS (NUM_SETS),
        .INIT_PC  (INIT_PC)
    ) i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .enq_valid  (enq_valid),
        .enq_block  (enq_block),
        .stall_enq  (stall_enq),
        .deq_valid  (deq_valid),
        .deq_ways   (deq_ways),
        .stall_deq  (stall_deq),
        .restart    (restart),
        .restart_pc (restart_pc)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic chunk_t random_chunk(input logic unc);
        logic [31:0] r;
        r = lcg_next();
        if (unc) begin
            return {r[31:18], 2'b11};
        end
        return {r[31:18], r[17] ? 2'b10 : {1'b0, r[16]}};
    endfunction

    // next block in fetch order with its successor PC
    function automatic fetch_block_t make_block(input logic [7:0] mask, input logic [7:0] unc);
        fetch_block_t blk;
        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
            blk.chunks[i] = random_chunk(unc[i]);
        end
        blk.valid_mask = mask;
        fetch_pc28 = fetch_pc28 + 1'b1;
        blk.after_pc28 = fetch_pc28;
        return blk;
    endfunction

    // ----------------------------------------
    // reference model

    // start markers and up to four instructions from the two oldest sets
    task automatic predict_issue(
        output deq_way_t [NUM_WAYS-1:0]  ways,
        output logic [WINDOW_CHUNKS-1:0] taken
    );
        chunk_t [WINDOW_CHUNKS-1:0] chunk;
        logic [WINDOW_CHUNKS-1:0]   valid;
        logic [WINDOW_CHUNKS-1:0]   start;
        logic [27:0]                set_pc28;
        int                         pos;
        int                         up;
        chunk = '0;
        valid = '0;
        ways = '0;
        taken = '0;
        for (int s = 0; s < 2; s++) begin
            if (model_blocks.size() > s) begin
                chunk[s*CHUNKS_PER_SET +: CHUNKS_PER_SET] = model_blocks[s].chunks;
                valid[s*CHUNKS_PER_SET +: CHUNKS_PER_SET] = model_blocks[s].valid_mask;
            end
        end
        for (int i = 0; i < WINDOW_CHUNKS; i++) begin
            start[i] = valid[i];
            if (i > 0 && start[i-1] && chunk[i-1][1:0] == 2'b11) begin
                start[i] = 1'b0;
            end
        end
        if (chunk[WINDOW_CHUNKS-1][1:0] == 2'b11) begin
            start[WINDOW_CHUNKS-1] = 1'b0;
        end
        pos = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            while (pos < WINDOW_CHUNKS && !start[pos]) begin
                pos++;
            end
            if (pos == WINDOW_CHUNKS) begin
                break;
            end
            // upper half is the next valid chunk in either set
            if (chunk[pos][1:0] == 2'b11) begin
                up = pos + 1;
                while (up < WINDOW_CHUNKS && !valid[up]) begin
                    up++;
                end
                if (up == WINDOW_CHUNKS) begin
                    break;
                end
                ways[w].uncompressed = 1'b1;
                ways[w].upper = chunk[up];
                taken[up] = 1'b1;
            end
            set_pc28 = (pos < CHUNKS_PER_SET) ? model_pc28 : model_blocks[0].after_pc28;
            ways[w].valid = 1'b1;
            ways[w].lower = chunk[pos];
            ways[w].pc = {set_pc28, pos[2:0], 1'b0};
            taken[pos] = 1'b1;
            pos++;
        end
    endtask

    task automatic advance_model();
        deq_way_t [NUM_WAYS-1:0]   ways;
        logic [WINDOW_CHUNKS-1:0]  taken;
        logic [CHUNKS_PER_SET-1:0] half;
        logic [1:0]                done;
        logic                      full;
        fetch_block_t              blk;
        full = (model_blocks.size() == NUM_SETS);
        predict_issue(ways, taken);
        done = '0;
        if (restart) begin
            model_blocks.delete();
            model_pc28 = restart_pc[31:4];
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (!stall_deq && model_blocks.size() > s) begin
                    blk = model_blocks[s];
                    half = taken[s*CHUNKS_PER_SET +: CHUNKS_PER_SET];
                    done[s] = (blk.valid_mask != '0) && ((blk.valid_mask & ~half) == '0);
                    blk.valid_mask = blk.valid_mask & ~half;
                    model_blocks[s] = blk;
                end
            end
            // a second set retires only together with the head
            if (done[0]) begin
                model_pc28 = done[1] ? model_blocks[1].after_pc28 : model_blocks[0].after_pc28;
                void'(model_blocks.pop_front());
                if (done[1]) begin
                    void'(model_blocks.pop_front());
                end
            end
            if (enq_valid && !full) begin
                model_blocks.push_back(enq_block);
            end
        end
    endtask

    // ----------------------------------------
    // compare tasks

    task automatic check_way(input string name, input deq_way_t exp, input deq_way_t act);
        string exp_text;
        string act_text;
        checks++;
        if (act !== exp) begin
            mismatches++;
            exp_text = $sformatf("v=%b u=%b lo=%h up=%h pc=%h",
                                 exp.valid, exp.uncompressed, exp.lower, exp.upper, exp.pc);
            act_text = $sformatf("v=%b u=%b lo=%h up=%h pc=%h",
                                 act.valid, act.uncompressed, act.lower, act.upper, act.pc);
            $display("MISMATCH %s: expected %s actual %s", name, exp_text, act_text);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic compare_outputs(input string name);
        deq_way_t [NUM_WAYS-1:0]  ways;
        logic [WINDOW_CHUNKS-1:0] taken;
        predict_issue(ways, taken);
        for (int w = 0; w < NUM_WAYS; w++) begin
            check_way(name, ways[w], deq_ways[w]);
        end
        check_bit({name, " deq_valid"}, ways[0].valid, deq_valid);
        check_bit({name, " stall_enq"}, model_blocks.size() == NUM_SETS, stall_enq);
    endtask

    // ----------------------------------------
    // cycle drivers called and returning at the falling edge

    task automatic drive_cycle(
        input string        name,
        input logic         ev,
        input fetch_block_t blk,
        input logic         sd,
        input logic         rs,
        input logic [31:0]  rpc
    );
        compare_outputs(name);
        enq_valid = ev;
        enq_block = blk;
        stall_deq = sd;
        restart = rs;
        restart_pc = rpc;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!sd && !rs && deq_ways[w].valid) begin
                issued++;
            end
        end
        @(posedge CLK);
        advance_model();
        @(negedge CLK);
    endtask

    task automatic idle_cycle(input string name, input logic sd);
        drive_cycle(name, 1'b0, '0, sd, 1'b0, '0);
    endtask

    task automatic push_block(input string name, input fetch_block_t blk, input logic sd);
        drive_cycle(name, 1'b1, blk, sd, 1'b0, '0);
    endtask

    task automatic drain(input string name);
        while (deq_valid) begin
            idle_cycle(name, 1'b0);
        end
        idle_cycle(name, 1'b0);
    endtask

    // ----------------------------------------
    // directed tests

    task automatic check_reset_state();
        check_bit("reset deq_valid", 1'b0, deq_valid);
        check_bit("reset stall_enq", 1'b0, stall_enq);
        idle_cycle("reset", 1'b0);
    endtask

    task automatic drain_compressed_pair();
        fetch_block_t pair [2];
        deq_way_t     exp;
        // blocks at 0x1000 and 0x1010 behind the reset PC
        for (int b = 0; b < 2; b++) begin
            pair[b] = make_block(8'hff, 8'h00);
            push_block("compressed", pair[b], 1'b1);
        end
        for (int c = 0; c < 4; c++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                exp = '0;
                exp.valid = 1'b1;
                exp.lower = pair[c/2].chunks[(c%2)*4 + w];
                exp.pc = 32'h1000 + 32'(8*c + 2*w);
                check_way("compressed sequence", exp, deq_ways[w]);
            end
            idle_cycle("compressed", 1'b0);
        end
        check_bit("compressed drained", 1'b0, deq_valid);
    endtask

    task automatic issue_mixed_blocks();
        fetch_block_t head;
        fetch_block_t tail;
        deq_way_t     straddle;
        logic         found;
        straddle = '0;
        straddle.pc = {fetch_pc28, 3'd7, 1'b0};
        // holes at 2 and 5 with 32-bit chunks at 0, 3 and 7
        // chunk 7 takes its upper half from the next set
        head = make_block(8'b1101_1011, 8'b1000_1001);
        tail = make_block(8'b0111_1101, 8'b0000_0100);
        straddle.valid = 1'b1;
        straddle.uncompressed = 1'b1;
        straddle.lower = head.chunks[7];
        straddle.upper = tail.chunks[0];
        push_block("mixed", head, 1'b1);
        push_block("mixed", tail, 1'b1);
        found = 1'b0;
        while (deq_valid) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (deq_ways[w].valid && deq_ways[w].pc == straddle.pc) begin
                    check_way("straddle", straddle, deq_ways[w]);
                    found = 1'b1;
                end
            end
            idle_cycle("mixed", 1'b0);
        end
        if (!found) begin
            other_errors++;
            $display("error: the instruction across the set boundary was never issued");
        end
        idle_cycle("mixed", 1'b0);
    endtask

    task automatic hold_under_stall();
        deq_way_t [NUM_WAYS-1:0]  held;
        logic [WINDOW_CHUNKS-1:0] taken;
        drive_cycle("backpressure restart", 1'b0, '0, 1'b1, 1'b1, 32'h0000_3000);
        fetch_pc28 = 28'h300;
        push_block("backpressure", make_block(8'hff, 8'h00), 1'b1);
        // model view of the first block held through the stall
        predict_issue(held, taken);
        repeat (3) begin
            idle_cycle("backpressure", 1'b1);
            for (int w = 0; w < NUM_WAYS; w++) begin
                check_way("stall hold", held[w], deq_ways[w]);
            end
        end
        for (int b = 1; b < NUM_SETS; b++) begin
            check_bit("not yet full", 1'b0, stall_enq);
            push_block("backpressure", make_block(8'hff, 8'h00), 1'b1);
        end
        check_bit("full", 1'b1, stall_enq);
        // offered while full and dropped
        push_block("ninth block", make_block(8'hff, 8'h00), 1'b1);
        issued = 0;
        drain("backpressure drain");
        if (issued != NUM_SETS * CHUNKS_PER_SET) begin
            other_errors++;
            $display("error: %0d instructions drained after a full buffer, %0d expected",
                     issued, NUM_SETS * CHUNKS_PER_SET);
        end
    endtask

    task automatic flush_on_restart();
        fetch_block_t blk;
        deq_way_t     exp;
        logic [31:0]  r;
        r = lcg_next();
        push_block("restart", make_block(8'hff, r[7:0]), 1'b1);
        r = lcg_next();
        push_block("restart", make_block(8'hff, r[7:0]), 1'b1);
        drive_cycle("restart", 1'b0, '0, 1'b1, 1'b1, 32'h0000_2000);
        check_bit("restart flush", 1'b0, deq_valid);
        fetch_pc28 = 28'h200;
        blk = make_block(8'hff, 8'h00);
        push_block("restart", blk, 1'b1);
        exp = '0;
        exp.valid = 1'b1;
        exp.lower = blk.chunks[0];
        exp.pc = 32'h0000_2000;
        check_way("restart first way", exp, deq_ways[0]);
        drain("restart drain");
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] rpc;
        logic [7:0]  mask;
        for (int n = 0; n < 300; n++) begin
            r = lcg_next();
            if (n == 150) begin
                rpc = {r[31:8], 8'h00};
                drive_cycle("random restart", 1'b0, '0, 1'b0, 1'b1, rpc);
                fetch_pc28 = rpc[31:4];
            end
            mask = (r[7:0] == 8'h00) ? 8'h81 : r[7:0];
            drive_cycle("random", r[16] | r[17], make_block(mask, r[15:8]),
                        r[18] & r[19], 1'b0, '0);
        end
        drain("random drain");
    endtask

    initial begin
        lcg_state = 32'h2620_c683;
        nRST = 1'b0;
        enq_valid = 1'b0;
        enq_block = '0;
        stall_deq = 1'b0;
        restart = 1'b0;
        restart_pc = '0;
        model_pc28 = INIT_PC[31:4];
        fetch_pc28 = INIT_PC[31:4];
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        check_reset_state();
        drain_compressed_pair();
        issue_mixed_blocks();
        hold_under_stall();
        flush_on_restart();
        random_traffic();

        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
logic/istream_pkg.sv
logic/set_store.sv
logic/chunk_window.sv
logic/way_extract.sv
logic/deq_merge.sv
logic/istream.sv
bench/tb_istream.sv

/* Makefile */
# Verilator build, run and lint for the instruction stream buffer

TOP      ?= tb_istream
RTL_TOP  ?= istream
LOG      ?= sim.log
VFLAGS   ?= -j 0
FILELIST ?= compile.f
BUILD    ?= obj_dir

SRCS     := $(shell grep '\.sv$$' $(FILELIST))
RTL_SRCS := $(shell grep '^logic/' $(FILELIST))
SIM      := $(BUILD)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	verilator --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

# pass or fail comes from the log, not the exit status
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD) $(LOG)
